// ==== common/recordPkg.sv ====
`include "record_settings.svh"

package recordPkg;

    typedef logic [`RECORD_WORD_BITS-1:0] recordWord_t;       // One stored word
    typedef logic [`RECORD_ADDR_BITS-1:0] recordAddr_t;       // Buffer address
    typedef logic [`RECORD_ADDR_BITS:0] recordCount_t;        // Word count, 0 to depth

    typedef logic [$clog2(`RECORD_WORD_BITS)-1:0] bitIndex_t; // Bit position in a word
    typedef logic [$clog2(`RECORD_RUN_LEN+1)-1:0] runCount_t; // Zero-run length

    // Controller FSM
    typedef enum logic [2:0] {
        idle,
        readReq,
        playStrobe,
        scanWord,
        done
    } ctrlState_t;

endpackage

// ==== common/record_settings.svh ====
`ifndef RECORD_SETTINGS_SVH
`define RECORD_SETTINGS_SVH

// Stored word layout
`define RECORD_WORD_BITS 32        // Bits packed per buffer word

// Buffer size, the address width has to follow the depth
`define RECORD_DEPTH     256       // Words in the record buffer
`define RECORD_ADDR_BITS 8         // log2 of the depth

// Zero-run check
`define RECORD_RUN_LEN   6         // Consecutive zeros that mark a valid stream

`endif

// ==== recordController/recordController.sv ====
`timescale 1ns/1ns

module recordController (
    input  logic                    clk,
    input  logic                    resetN,
    input  logic                    enable,
    input  logic                    writeOut,
    input  logic                    determineOW,
    input  logic                    recording,
    input  recordPkg::recordCount_t wordCount,
    output logic                    rdCyc,
    output logic                    rdStb,
    output recordPkg::recordAddr_t  rdAdr,
    input  recordPkg::recordWord_t  rdDat,
    input  logic                    rdAck,
    output logic                    pulseWrite,
    output logic                    complete,
    output logic                    owTrue,
    output recordPkg::recordWord_t  playbackOut
);

    recordPkg::ctrlState_t state;
    logic playMode;
    logic enableD;
    logic startPlay;
    logic startScan;
    logic lastWord;
    logic detLoad;
    logic detWordDone;
    logic detFound;

    // Commands only from idle with no recording running and playback first
    assign startPlay = (state == recordPkg::idle) && !recording && writeOut;
    assign startScan = (state == recordPkg::idle) && !recording && !writeOut && determineOW;

    assign lastWord   = ({1'b0, rdAdr} == wordCount - 1'b1);
    assign detLoad    = (state == recordPkg::readReq) && rdAck && !playMode;
    assign rdStb      = (state == recordPkg::readReq);          // Falls the cycle after ack
    assign rdCyc      = rdStb;
    assign pulseWrite = (state == recordPkg::playStrobe);

    zeroRunDetector runDet (
        .clk      (clk),
        .resetN   (resetN),
        .clear    (startScan),
        .load     (detLoad),
        .word     (rdDat),
        .wordDone (detWordDone),
        .found    (detFound)
    );

    always_ff @(posedge clk) begin
        if (!resetN) begin
            state    <= recordPkg::idle;
            playMode <= 1'b0;
            rdAdr    <= '0;
            enableD  <= 1'b0;
            complete <= 1'b0;
            owTrue   <= 1'b0;
        end else begin
            enableD <= enable;
            case (state)
                recordPkg::idle: begin
                    rdAdr <= '0;
                    if (startPlay || startScan) begin
                        playMode <= startPlay;
                        state    <= (wordCount == '0) ? recordPkg::done : recordPkg::readReq;
                    end
                end
                recordPkg::readReq: begin
                    if (rdAck) begin
                        state <= playMode ? recordPkg::playStrobe : recordPkg::scanWord;
                    end
                end
                recordPkg::playStrobe: begin
                    if (lastWord) begin
                        state <= recordPkg::done;
                    end else begin
                        rdAdr <= rdAdr + 1'b1;
                        state <= recordPkg::readReq;
                    end
                end
                recordPkg::scanWord: begin
                    if (detFound || (detWordDone && lastWord)) begin
                        state <= recordPkg::done;               // Early stop on a run
                    end else if (detWordDone) begin
                        rdAdr <= rdAdr + 1'b1;
                        state <= recordPkg::readReq;
                    end
                end
                recordPkg::done: begin
                    state <= recordPkg::idle;
                end
                default: begin
                    state <= recordPkg::idle;
                end
            endcase
            if (enable && !enableD) begin                       // New recording starts
                complete <= 1'b0;
                owTrue   <= 1'b0;
            end else if ((state == recordPkg::done) && !playMode) begin
                complete <= 1'b1;
                owTrue   <= detFound;
            end
        end
    end

    always_ff @(posedge clk) begin
        if ((state == recordPkg::readReq) && rdAck && playMode) begin
            playbackOut <= rdDat;                               // Held through playStrobe
        end
    end

    // Every strobe needs a fresh read of at least two cycles before the next one
    assert property (@(posedge clk) disable iff (!resetN)
        pulseWrite |=> !pulseWrite ##1 !pulseWrite)
        else $error("pulseWrite high for two cycles or repeated without a full read");

endmodule

// ==== recordController/zeroRunDetector.sv ====
`timescale 1ns/1ns
`include "record_settings.svh"

module zeroRunDetector (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   clear,
    input  logic                   load,
    input  recordPkg::recordWord_t word,
    output logic                   wordDone,
    output logic                   found
);

    recordPkg::recordWord_t shiftReg;
    recordPkg::bitIndex_t bitCnt;
    recordPkg::runCount_t runCount;
    logic busy;
    logic zeroBit;

    assign zeroBit  = busy && !shiftReg[0];                 // Bit under test is a zero
    assign wordDone = busy && (bitCnt == '1);               // Last bit of the word

    always_ff @(posedge clk) begin
        if (!resetN || clear) begin
            busy     <= 1'b0;
            bitCnt   <= '0;
            runCount <= '0;
            found    <= 1'b0;
        end else begin
            if (load) begin
                busy   <= 1'b1;
                bitCnt <= '0;                               // runCount carries across words
            end else if (busy) begin
                bitCnt <= bitCnt + 1'b1;
                if (wordDone) begin
                    busy <= 1'b0;
                end
                if (!zeroBit) begin
                    runCount <= '0;
                end else if (runCount != `RECORD_RUN_LEN) begin
                    runCount <= runCount + 1'b1;            // Saturates at run length
                end
                if (zeroBit && (runCount == `RECORD_RUN_LEN - 1)) begin
                    found <= 1'b1;                          // Sticky until clear
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            shiftReg <= word;
        end else if (busy) begin
            shiftReg <= shiftReg >> 1;
        end
    end

endmodule

// ==== rtl/recordBuffer.sv ====
`timescale 1ns/1ns
`include "record_settings.svh"

module recordBuffer (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   wrCyc,
    input  logic                   wrStb,
    input  recordPkg::recordAddr_t wrAdr,
    input  recordPkg::recordWord_t wrDat,
    output logic                   wrAck,
    input  logic                   rdCyc,
    input  logic                   rdStb,
    input  recordPkg::recordAddr_t rdAdr,
    output recordPkg::recordWord_t rdDat,
    output logic                   rdAck
);

    recordPkg::recordWord_t mem [`RECORD_DEPTH];
    logic wrReq;
    logic rdReq;

    assign wrReq = wrCyc && wrStb && !wrAck;                  // New cycle, not yet answered
    assign rdReq = rdCyc && rdStb && !rdAck;

    always_ff @(posedge clk) begin
        if (!resetN) begin
            wrAck <= 1'b0;
            rdAck <= 1'b0;
        end else begin
            wrAck <= wrReq;                                   // One-cycle ack pulses
            rdAck <= rdReq;
        end
    end

    always_ff @(posedge clk) begin
        if (wrAck) begin
            mem[wrAdr] <= wrDat;                              // Commit on the ack cycle
        end
        if (rdReq) begin
            rdDat <= mem[rdAdr];                              // Valid with rdAck
        end
    end

    // An ack only answers a strobe that was seen the cycle before and still stands
    assert property (@(posedge clk) disable iff (!resetN) wrAck |-> $past(wrStb) && wrStb)
        else $error("wrAck raised without wrStb");
    assert property (@(posedge clk) disable iff (!resetN) rdAck |-> $past(rdStb) && rdStb)
        else $error("rdAck raised without rdStb");

endmodule

// ==== rtl/recordMaster.sv ====
`timescale 1ns/1ns

module recordMaster (
    input  logic                   clk,
    input  logic                   resetN,
    input  logic                   enable,
    input  logic                   writeOut,
    input  logic                   determineOW,
    input  logic                   samplePulse,
    input  logic                   dIn,
    output logic                   owTrue,
    output logic                   complete,
    output logic                   pulseWrite,
    output recordPkg::recordWord_t playbackOut
);

    // Write bus, recorder to buffer
    logic wrCyc;
    logic wrStb;
    logic wrAck;
    recordPkg::recordAddr_t wrAdr;
    recordPkg::recordWord_t wrDat;

    // Read bus, controller to buffer
    logic rdCyc;
    logic rdStb;
    logic rdAck;
    recordPkg::recordAddr_t rdAdr;
    recordPkg::recordWord_t rdDat;

    recordPkg::recordCount_t wordCount;
    logic recording;

    sampleRecorder recorder (
        .clk, .resetN, .enable, .samplePulse, .dIn,
        .wrCyc, .wrStb, .wrAdr, .wrDat, .wrAck,
        .wordCount, .recording
    );

    recordBuffer buffer (
        .clk, .resetN,
        .wrCyc, .wrStb, .wrAdr, .wrDat, .wrAck,
        .rdCyc, .rdStb, .rdAdr, .rdDat, .rdAck
    );

    recordController controller (
        .clk, .resetN, .enable, .writeOut, .determineOW, .recording, .wordCount,
        .rdCyc, .rdStb, .rdAdr, .rdDat, .rdAck,
        .pulseWrite, .complete, .owTrue, .playbackOut
    );

endmodule

// ==== rtl/sampleRecorder.sv ====
`timescale 1ns/1ns
`include "record_settings.svh"

module sampleRecorder (
    input  logic                    clk,
    input  logic                    resetN,
    input  logic                    enable,
    input  logic                    samplePulse,
    input  logic                    dIn,
    output logic                    wrCyc,
    output logic                    wrStb,
    output recordPkg::recordAddr_t  wrAdr,
    output recordPkg::recordWord_t  wrDat,
    input  logic                    wrAck,
    output recordPkg::recordCount_t wordCount,
    output logic                    recording
);

    logic enableD;
    logic enableRise;
    logic enableFall;
    logic takeSample;
    logic lastBit;
    logic flushPending;
    logic flushNow;
    logic flushNeeded;
    recordPkg::bitIndex_t bitIdx;
    recordPkg::recordWord_t shiftReg;
    recordPkg::recordWord_t shiftNext;
    recordPkg::recordWord_t holdWord;
    logic [2*`RECORD_WORD_BITS-1:0] padSpan;

    assign enableRise = enable && !enableD;
    assign enableFall = !enable && enableD;
    assign takeSample = enable && samplePulse;
    assign lastBit    = takeSample && (bitIdx == '1);                   // 32nd bit of a word
    assign shiftNext  = {dIn, shiftReg[`RECORD_WORD_BITS-1:1]};         // LSB first

    // Partial word sits at the top of shiftReg and is pulled down over ones
    assign padSpan = {{`RECORD_WORD_BITS{1'b1}}, shiftReg} >> (`RECORD_WORD_BITS - bitIdx);

    assign flushNow    = flushPending && !wrStb;                        // Bus free for the flush
    assign flushNeeded = flushPending || (enableFall && (bitIdx != '0));

    assign wrCyc = wrStb;
    assign wrAdr = wordCount[`RECORD_ADDR_BITS-1:0];                     // Next free word
    assign wrDat = holdWord;

    always_ff @(posedge clk) begin
        if (!resetN) begin
            enableD      <= 1'b0;
            bitIdx       <= '0;
            wordCount    <= '0;
            flushPending <= 1'b0;
            wrStb        <= 1'b0;
            recording    <= 1'b0;
        end else begin
            enableD <= enable;
            if (enableRise) begin                                       // New recording
                bitIdx       <= '0;
                wordCount    <= '0;
                flushPending <= 1'b0;
            end else begin
                if (takeSample) begin
                    bitIdx <= bitIdx + 1'b1;
                end else if (flushNow) begin
                    bitIdx <= '0;
                end
                if (wrAck) begin
                    wordCount <= wordCount + 1'b1;
                end
                if (enableFall && (bitIdx != '0)) begin
                    flushPending <= 1'b1;
                end else if (flushNow) begin
                    flushPending <= 1'b0;
                end
            end
            if (lastBit || flushNow) begin
                wrStb <= 1'b1;
            end else if (wrAck) begin
                wrStb <= 1'b0;                                          // Drop after ack
            end
            if (enableRise) begin
                recording <= 1'b1;
            end else if (!enable && !flushNeeded && (wrAck || !wrStb)) begin
                recording <= 1'b0;                                      // Last write done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (takeSample) begin
            shiftReg <= shiftNext;
        end
        if (lastBit) begin
            holdWord <= shiftNext;                                      // Frees shiftReg
        end else if (flushNow) begin
            holdWord <= padSpan[`RECORD_WORD_BITS-1:0];
        end
    end

    // A started write holds its address and data until the buffer answers
    assert property (@(posedge clk) disable iff (!resetN)
        wrStb && !wrAck |=> wrStb && $stable(wrAdr) && $stable(wrDat))
        else $error("write cycle changed before wrAck");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module recordMasterTb -f verilog.f -o recordSim \
    && ./obj_dir/recordSim | tee sim.log \
    || echo "Build or simulation run failed"

grep -q "^=== PASS ===$" sim.log 2>/dev/null \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }

// ==== verif/recordMasterTb.sv ====
`timescale 1ns/1ns
`include "record_settings.svh"

module recordMasterTb;

    // About 174 samples at 6 cycles plus 4 word scans at 34 cycles plus playback
    // and the enable windows come to roughly 1300 cycles
    // Three times that gives the limit
    localparam int cycleLimit = 4000;
    localparam int maxWords   = 8;
    localparam int freeBits   = 0;       // Plain random bits
    localparam int cappedRuns = 1;       // Zero runs held to 5
    localparam int boundaryRun = 2;      // Capped with one run of 6 over words 0 and 1

    logic clk;
    logic resetN;
    logic enable;
    logic writeOut;
    logic determineOW;
    logic samplePulse;
    logic dIn;
    logic owTrue;
    logic complete;
    logic pulseWrite;
    recordPkg::recordWord_t playbackOut;

    integer seed;
    int cycleCount = 0;
    int passCount;
    int failCount;
    int errorCount;
    string testName;

    bit sentBits[$];                                 // Reference model input
    recordPkg::recordWord_t modelWords [maxWords];
    int modelCount;
    logic expOw;
    int playIdx;
    logic idleCheck;
    logic playEnd;
    logic scanEnd;
    logic clearCheck;
    logic quietWindow;

    recordMaster dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (!resetN) begin
            playIdx <= 0;
        end else if (pulseWrite) begin
            playIdx <= playIdx + 1;                  // Strobes seen so far
        end
    end

    assert property (@(posedge clk) disable iff (!resetN)
        idleCheck |-> !pulseWrite && !complete && !owTrue)
        else begin
            errorCount++;
            $display("Error: %s expected outputs 000 actual %b%b%b", testName,
                $sampled(pulseWrite), $sampled(complete), $sampled(owTrue));
        end
    assert property (@(posedge clk) disable iff (!resetN)
        pulseWrite |-> playIdx < modelCount)
        else begin
            errorCount++;
            $display("Error: %s pulseWrite strobed more often than words were stored",
                testName);
        end
    assert property (@(posedge clk) disable iff (!resetN)
        pulseWrite && (playIdx < modelCount) |-> playbackOut == modelWords[playIdx])
        else begin
            errorCount++;
            $display("Error: %s word %0d expected %h actual %h", testName, $sampled(playIdx),
                modelWords[$sampled(playIdx)], $sampled(playbackOut));
        end
    assert property (@(posedge clk) disable iff (!resetN)
        playEnd |-> playIdx == modelCount)
        else begin
            errorCount++;
            $display("Error: %s strobes expected %0d actual %0d", testName, modelCount,
                $sampled(playIdx));
        end
    assert property (@(posedge clk) disable iff (!resetN)
        scanEnd |-> complete && (owTrue == expOw))
        else begin
            errorCount++;
            $display("Error: %s complete/owTrue expected 1%b actual %b%b", testName, expOw,
                $sampled(complete), $sampled(owTrue));
        end
    assert property (@(posedge clk) disable iff (!resetN)
        clearCheck |-> !complete && !owTrue)
        else begin
            errorCount++;
            $display("Error: %s complete/owTrue expected 00 actual %b%b", testName,
                $sampled(complete), $sampled(owTrue));
        end
    assert property (@(posedge clk) disable iff (!resetN)
        quietWindow |-> !complete)
        else begin
            errorCount++;
            $display("Error: %s complete rose on a command given during recording", testName);
        end

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    function automatic bit pickBit(input int mode, input int index, input int zeroRun);
        logic [31:0] r;
        r = $random(seed);
        if (mode == boundaryRun && index >= 29 && index <= 34) begin
            return 1'b0;
        end
        if (mode == boundaryRun && (index == 28 || index == 35)) begin
            return 1'b1;                             // Fences the boundary run
        end
        if (mode != freeBits && zeroRun >= `RECORD_RUN_LEN - 1) begin
            return 1'b1;
        end
        return r[0];
    endfunction

    task automatic buildModel();
        int run;
        run = 0;
        expOw = 1'b0;
        modelCount = (sentBits.size() + `RECORD_WORD_BITS - 1) / `RECORD_WORD_BITS;
        for (int w = 0; w < maxWords; w++) begin
            modelWords[w] = '1;                      // Unused upper bits stay one
        end
        for (int i = 0; i < sentBits.size(); i++) begin
            modelWords[i / `RECORD_WORD_BITS][i % `RECORD_WORD_BITS] = sentBits[i];
        end
        for (int i = 0; i < modelCount * `RECORD_WORD_BITS; i++) begin
            if (modelWords[i / `RECORD_WORD_BITS][i % `RECORD_WORD_BITS]) begin
                run = 0;
            end else begin
                run++;
                if (run >= `RECORD_RUN_LEN) begin
                    expOw = 1'b1;
                end
            end
        end
    endtask

    task automatic recordStream(input int count, input int mode);
        int zeroRun;
        int gap;
        bit b;
        zeroRun = 0;
        sentBits.delete();
        enable = 1'b1;
        waitCycles(2);
        for (int i = 0; i < count; i++) begin
            b = pickBit(mode, i, zeroRun);
            zeroRun = b ? 0 : zeroRun + 1;
            sentBits.push_back(b);
            gap = 4 + ($unsigned($random(seed)) % 3);    // 4 to 6 cycles apart
            samplePulse = 1'b1;
            dIn = b;
            waitCycles(1);
            samplePulse = 1'b0;
            waitCycles(gap - 1);
        end
        enable = 1'b0;
        while (dut.recording) begin
            @(negedge clk);
        end
        buildModel();
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorCount = 0;
    endtask

    task automatic reportTest();
        if (errorCount == 0) begin
            passCount++;
            $display("Test %s passed", testName);
        end else begin
            failCount++;
            $display("Test %s failed with %0d errors", testName, errorCount);
        end
    endtask

    initial begin
        seed = 28516;
        resetN = 1'b0;
        enable = 1'b0;
        writeOut = 1'b0;
        determineOW = 1'b0;
        samplePulse = 1'b0;
        dIn = 1'b0;
        {idleCheck, playEnd, scanEnd, clearCheck, quietWindow} = '0;
        passCount = 0;
        failCount = 0;
        modelCount = 0;
        expOw = 1'b0;
        startTest("resetQuiet");
        waitCycles(8);
        resetN = 1'b1;

        idleCheck = 1'b1;
        waitCycles(10);
        idleCheck = 1'b0;
        reportTest();

        startTest("playback70");
        recordStream(70, freeBits);
        writeOut = 1'b1;
        waitCycles(1);
        writeOut = 1'b0;
        while (dut.controller.state == recordPkg::idle) begin
            @(negedge clk);
        end
        while (dut.controller.state != recordPkg::idle) begin
            @(negedge clk);
        end
        playEnd = 1'b1;
        waitCycles(1);
        playEnd = 1'b0;
        reportTest();

        startTest("shortRuns40");
        recordStream(40, cappedRuns);
        determineOW = 1'b1;
        waitCycles(1);
        determineOW = 1'b0;
        while (!complete) begin
            @(negedge clk);
        end
        scanEnd = 1'b1;
        waitCycles(1);
        scanEnd = 1'b0;
        reportTest();

        startTest("boundaryRun");
        recordStream(64, boundaryRun);
        determineOW = 1'b1;
        waitCycles(1);
        determineOW = 1'b0;
        while (!complete) begin
            @(negedge clk);
        end
        scanEnd = 1'b1;
        waitCycles(1);
        scanEnd = 1'b0;
        reportTest();

        startTest("enableClears");
        enable = 1'b1;                               // Rising edge clears the scan result
        waitCycles(1);
        clearCheck = 1'b1;
        waitCycles(1);
        clearCheck = 1'b0;
        quietWindow = 1'b1;
        determineOW = 1'b1;
        waitCycles(1);
        determineOW = 1'b0;
        waitCycles(40);                              // Longer than a one word scan
        enable = 1'b0;
        waitCycles(4);
        quietWindow = 1'b0;
        reportTest();

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
common/recordPkg.sv
rtl/sampleRecorder.sv
rtl/recordBuffer.sv
recordController/zeroRunDetector.sv
recordController/recordController.sv
rtl/recordMaster.sv
verif/recordMasterTb.sv
